/* hw/quarkPkg.sv */
package quarkPkg;

   // Register and data word
   typedef logic [31:0] xlen_t;

   // Register index
   typedef logic [4:0] regIdx_t;

   // Register-register format
   typedef struct packed {
      logic [6:0] funct7;
      regIdx_t    rs2;
      regIdx_t    rs1;
      logic [2:0] funct3;
      regIdx_t    rd;
      logic [6:0] opcode;
   } rFmt_t;

   // Immediate, load and jalr format
   typedef struct packed {
      logic [11:0] imm11_0;
      regIdx_t     rs1;
      logic [2:0]  funct3;
      regIdx_t     rd;
      logic [6:0]  opcode;
   } iFmt_t;

   // Store format, immediate split around rs2/rs1
   typedef struct packed {
      logic [6:0] imm11_5;
      regIdx_t    rs2;
      regIdx_t    rs1;
      logic [2:0] funct3;
      logic [4:0] imm4_0;
      logic [6:0] opcode;
   } sFmt_t;

   // Branch format with scrambled offset bits
   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      regIdx_t    rs2;
      regIdx_t    rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
   } bFmt_t;

   // Upper immediate format
   typedef struct packed {
      logic [19:0] imm31_12;
      regIdx_t     rd;
      logic [6:0]  opcode;
   } uFmt_t;

   // Jump format
   typedef struct packed {
      logic        imm20;
      logic [9:0]  imm10_1;
      logic        imm11;
      logic [7:0]  imm19_12;
      regIdx_t     rd;
      logic [6:0]  opcode;
   } jFmt_t;

   // One instruction word seen through every encoding
   typedef union packed {
      rFmt_t rFmt;
      iFmt_t iFmt;
      sFmt_t sFmt;
      bFmt_t bFmt;
      uFmt_t uFmt;
      jFmt_t jFmt;
   } instrWord_u;

   // RV32I major opcodes
   localparam logic [6:0] OP_LOAD    = 7'b0000011;
   localparam logic [6:0] OP_ALU_IMM = 7'b0010011;
   localparam logic [6:0] OP_AUIPC   = 7'b0010111;
   localparam logic [6:0] OP_STORE   = 7'b0100011;
   localparam logic [6:0] OP_ALU_REG = 7'b0110011;
   localparam logic [6:0] OP_LUI     = 7'b0110111;
   localparam logic [6:0] OP_BRANCH  = 7'b1100011;
   localparam logic [6:0] OP_JALR    = 7'b1100111;
   localparam logic [6:0] OP_JAL     = 7'b1101111;

   // Opcode class, at most one flag set
   typedef struct packed {
      logic load;
      logic aluImm;
      logic auipc;
      logic store;
      logic aluReg;
      logic lui;
      logic branch;
      logic jalr;
      logic jal;
   } opClass_t;

   // Everything the datapath needs from one instruction
   typedef struct packed {
      opClass_t   opClass;
      regIdx_t    rd;
      logic [7:0] funct3Is;
      logic       arith;
      xlen_t      iImm;
      xlen_t      sImm;
      xlen_t      uImm;
      xlen_t      pcImm;
   } decoded_t;

   // One-hot FSM state and its bit positions
   typedef logic [3:0] fsmState_t;

   localparam int fetchInstrBit   = 0;
   localparam int waitInstrBit    = 1;
   localparam int executeBit      = 2;
   localparam int waitAluOrMemBit = 3;

   localparam fsmState_t fetchInstr   = fsmState_t'(1) << fetchInstrBit;
   localparam fsmState_t waitInstr    = fsmState_t'(1) << waitInstrBit;
   localparam fsmState_t execute      = fsmState_t'(1) << executeBit;
   localparam fsmState_t waitAluOrMem = fsmState_t'(1) << waitAluOrMemBit;

   // Core to memory
   typedef struct packed {
      xlen_t      addr;
      xlen_t      wdata;
      logic [3:0] wmask;
      logic       rstrb;
   } memReq_t;

   // Memory to core
   typedef struct packed {
      xlen_t rdata;
      logic  rbusy;
      logic  wbusy;
   } memRsp_t;

endpackage

/* hw/instrDecoder.sv */
`timescale 1ns/100ps

module instrDecoder (
   input  quarkPkg::instrWord_u instr,
   output quarkPkg::decoded_t   dec
);

   logic [6:0]      opcode;
   quarkPkg::xlen_t bImm;
   quarkPkg::xlen_t jImm;
   quarkPkg::xlen_t uImm;

   // Opcode sits at the same place in every format
   assign opcode = instr.rFmt.opcode;

   // Opcode classes
   assign dec.opClass.load   = (opcode == quarkPkg::OP_LOAD);
   assign dec.opClass.aluImm = (opcode == quarkPkg::OP_ALU_IMM);
   assign dec.opClass.auipc  = (opcode == quarkPkg::OP_AUIPC);
   assign dec.opClass.store  = (opcode == quarkPkg::OP_STORE);
   assign dec.opClass.aluReg = (opcode == quarkPkg::OP_ALU_REG);
   assign dec.opClass.lui    = (opcode == quarkPkg::OP_LUI);
   assign dec.opClass.branch = (opcode == quarkPkg::OP_BRANCH);
   assign dec.opClass.jalr   = (opcode == quarkPkg::OP_JALR);
   assign dec.opClass.jal    = (opcode == quarkPkg::OP_JAL);

   // Destination register
   assign dec.rd = instr.rFmt.rd;

   // funct3 in one-hot form so each ALU/branch term tests a single bit
   assign dec.funct3Is = 8'b0000_0001 << instr.rFmt.funct3;

   // Bit 30 selects SUB and SRA
   assign dec.arith = instr.rFmt.funct7[5];

   // I-type immediate, sign extended
   assign dec.iImm = {{20{instr.iFmt.imm11_0[11]}}, instr.iFmt.imm11_0};

   // S-type immediate
   assign dec.sImm = {
      {20{instr.sFmt.imm11_5[6]}},
      instr.sFmt.imm11_5,
      instr.sFmt.imm4_0
   };

   // B-type offset, always even
   assign bImm = {
      {19{instr.bFmt.imm12}},
      instr.bFmt.imm12,
      instr.bFmt.imm11,
      instr.bFmt.imm10_5,
      instr.bFmt.imm4_1,
      1'b0
   };

   // J-type offset, always even
   assign jImm = {
      {11{instr.jFmt.imm20}},
      instr.jFmt.imm20,
      instr.jFmt.imm19_12,
      instr.jFmt.imm11,
      instr.jFmt.imm10_1,
      1'b0
   };

   // Upper immediate, low 12 bits cleared
   assign uImm     = {instr.uFmt.imm31_12, 12'h000};
   assign dec.uImm = uImm;

   // Offset for the shared PC adder
   // jal takes jImm, auipc takes uImm, branches take bImm
   assign dec.pcImm = dec.opClass.jal   ? jImm :
                      dec.opClass.auipc ? uImm :
                                          bImm;

endmodule

/* hw/regFile.sv */
`timescale 1ns/100ps

module regFile (
   input  logic                 clk,
   input  quarkPkg::instrWord_u srcWord,
   input  logic                 latch,
   input  logic                 writeBack,
   input  quarkPkg::regIdx_t    rd,
   input  quarkPkg::xlen_t      writeBackData,
   output quarkPkg::xlen_t      rs1,
   output quarkPkg::xlen_t      rs2
);

   // 32 entries, entry 0 never written
   quarkPkg::xlen_t regs [32];

   // Single write port
   always_ff @(posedge clk) begin
      if (writeBack && (rd != 5'd0)) begin
         regs[rd] <= writeBackData;
      end
   end

   // Operand read straight off the incoming instruction word
   // x0 is forced to zero on read, so the array needs no init
   always_ff @(posedge clk) begin
      if (latch) begin
         rs1 <= (srcWord.rFmt.rs1 == 5'd0) ? 32'd0 : regs[srcWord.rFmt.rs1];
         rs2 <= (srcWord.rFmt.rs2 == 5'd0) ? 32'd0 : regs[srcWord.rFmt.rs2];
      end
   end

endmodule

/* hw/execUnit.sv */
`timescale 1ns/100ps

module execUnit (
   input  logic               clk,
   input  logic               reset,
   input  quarkPkg::decoded_t dec,
   input  quarkPkg::xlen_t    rs1,
   input  quarkPkg::xlen_t    rs2,
   input  logic               start,
   output quarkPkg::xlen_t    aluOut,
   output quarkPkg::xlen_t    aluPlus,
   output logic               predicate,
   output logic               aluBusy
);

   quarkPkg::xlen_t aluIn2;
   logic [32:0]     aluMinus;
   logic            lt;
   logic            ltu;
   logic            eq;
   logic            isShift;
   logic            subtract;
   quarkPkg::xlen_t aluReg;
   logic [4:0]      aluShamt;

   // Second operand
   // rs2 for register ops and branches, iImm for the rest
   assign aluIn2 = (dec.opClass.aluReg | dec.opClass.branch) ? rs2 : dec.iImm;

   // Adder shared by ADD, ADDI and the jalr target
   assign aluPlus = rs1 + aluIn2;

   // One 33-bit subtract gives SUB and all three comparisons
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1} + 33'd1;
   assign ltu      = aluMinus[32];
   // Signed compare only differs from unsigned when the signs differ
   assign lt       = (rs1[31] ^ aluIn2[31]) ? rs1[31] : aluMinus[32];
   assign eq       = (aluMinus[31:0] == 32'd0);

   // ADDI has no SUB form, bit 30 is part of its immediate
   assign subtract = dec.arith & dec.opClass.aluReg;

   assign isShift = dec.funct3Is[1] | dec.funct3Is[5];

   // Result mux, one funct3 bit active at a time
   assign aluOut =
      (dec.funct3Is[0] ? (subtract ? aluMinus[31:0] : aluPlus) : 32'd0) |
      (dec.funct3Is[2] ? {31'd0, lt}                           : 32'd0) |
      (dec.funct3Is[3] ? {31'd0, ltu}                          : 32'd0) |
      (dec.funct3Is[4] ? (rs1 ^ aluIn2)                        : 32'd0) |
      (dec.funct3Is[6] ? (rs1 | aluIn2)                        : 32'd0) |
      (dec.funct3Is[7] ? (rs1 & aluIn2)                        : 32'd0) |
      (isShift         ? aluReg                                : 32'd0);

   // Busy while shift steps remain
   assign aluBusy = |aluShamt;

   // Remaining shift count
   always_ff @(posedge clk) begin
      if (!reset) begin
         aluShamt <= 5'd0;
      end else if (start && isShift) begin
         aluShamt <= aluIn2[4:0];
      end else if (aluBusy) begin
         aluShamt <= aluShamt - 5'd1;
      end
   end

   // Shift register, one bit per cycle
   always_ff @(posedge clk) begin
      if (start && isShift) begin
         aluReg <= rs1;
      end else if (aluBusy) begin
         // SLL shifts left, SRL/SRA shift right with optional sign fill
         aluReg <= dec.funct3Is[1] ? {aluReg[30:0], 1'b0} :
                                     {dec.arith & aluReg[31], aluReg[31:1]};
      end
   end

   // Branch condition
   assign predicate = (dec.funct3Is[0] &  eq)  |   // BEQ
                      (dec.funct3Is[1] & !eq)  |   // BNE
                      (dec.funct3Is[4] &  lt)  |   // BLT
                      (dec.funct3Is[5] & !lt)  |   // BGE
                      (dec.funct3Is[6] &  ltu) |   // BLTU
                      (dec.funct3Is[7] & !ltu);    // BGEU

endmodule

/* hw/pcUnit.sv */
`timescale 1ns/100ps

module pcUnit #(
   parameter logic [31:0] resetAddr = 32'h0000_0000,
   parameter int          addrWidth = 24
) (
   input  logic                clk,
   input  logic                reset,
   input  quarkPkg::fsmState_t state,
   input  quarkPkg::decoded_t  dec,
   input  quarkPkg::xlen_t     rs1,
   input  quarkPkg::xlen_t     aluPlus,
   input  logic                predicate,
   output quarkPkg::xlen_t     pc,
   output quarkPkg::xlen_t     pcPlus4,
   output quarkPkg::xlen_t     pcPlusImm,
   output quarkPkg::xlen_t     memAddr
);

   logic [addrWidth-1:0] pcReg;
   logic [addrWidth-1:0] pcPlus4Int;
   logic [addrWidth-1:0] pcPlusImmInt;
   logic [addrWidth-1:0] lsAddr;
   logic                 jumpToImm;

   // Sequential successor
   assign pcPlus4Int = pcReg + addrWidth'(4);

   // Shared adder for branches, jal and auipc
   assign pcPlusImmInt = pcReg + dec.pcImm[addrWidth-1:0];

   // Load/store address, only the store uses sImm
   assign lsAddr = rs1[addrWidth-1:0] +
                   (dec.opClass.store ? dec.sImm[addrWidth-1:0] : dec.iImm[addrWidth-1:0]);

   assign jumpToImm = dec.opClass.jal | (dec.opClass.branch & predicate);

   // Next PC taken at the execute edge
   always_ff @(posedge clk) begin
      if (!reset) begin
         pcReg <= resetAddr[addrWidth-1:0];
      end else if (state[quarkPkg::executeBit]) begin
         pcReg <= dec.opClass.jalr ? {aluPlus[addrWidth-1:1], 1'b0} :
                  jumpToImm        ? pcPlusImmInt :
                                     pcPlus4Int;
      end
   end

   // Narrow internal addresses are zero extended on the way out
   assign pc        = quarkPkg::xlen_t'(pcReg);
   assign pcPlus4   = quarkPkg::xlen_t'(pcPlus4Int);
   assign pcPlusImm = quarkPkg::xlen_t'(pcPlusImmInt);

   // Instruction address during fetch, data address otherwise
   assign memAddr = (state[quarkPkg::fetchInstrBit] | state[quarkPkg::waitInstrBit]) ?
                    pc : quarkPkg::xlen_t'(lsAddr);

endmodule

/* hw/controlFsm.sv */
`timescale 1ns/100ps

module controlFsm (
   input  logic                 clk,
   input  logic                 reset,
   input  quarkPkg::decoded_t   dec,
   input  quarkPkg::memRsp_t    memRsp,
   input  logic                 aluBusy,
   input  quarkPkg::xlen_t      aluOut,
   input  quarkPkg::xlen_t      pcPlus4,
   input  quarkPkg::xlen_t      pcPlusImm,
   input  quarkPkg::xlen_t      rs2,
   output quarkPkg::fsmState_t  state,
   output quarkPkg::instrWord_u instr,
   output logic                 latch,
   output logic                 aluStart,
   output logic                 writeBack,
   output quarkPkg::xlen_t      writeBackData,
   output quarkPkg::xlen_t      wdata,
   output logic [3:0]           wmask,
   output logic                 rstrb
);

   logic isAlu;
   logic needToWait;

   assign isAlu = dec.opClass.aluImm | dec.opClass.aluReg;

   // Loads, stores and shifts park in waitAluOrMem
   assign needToWait = dec.opClass.load | dec.opClass.store |
                       (isAlu & (dec.funct3Is[1] | dec.funct3Is[5]));

   // Instruction arrives once rbusy drops in waitInstr
   assign latch = state[quarkPkg::waitInstrBit] & !memRsp.rbusy;

   always_ff @(posedge clk) begin
      if (latch) begin
         instr <= memRsp.rdata;
      end
   end

   // Out of reset wait for the bus to go idle before the first fetch
   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= quarkPkg::waitAluOrMem;
      end else begin
         case (1'b1)
            state[quarkPkg::fetchInstrBit]: state <= quarkPkg::waitInstr;
            state[quarkPkg::waitInstrBit]: begin
               if (!memRsp.rbusy) begin
                  state <= quarkPkg::execute;
               end
            end
            state[quarkPkg::executeBit]: begin
               state <= needToWait ? quarkPkg::waitAluOrMem : quarkPkg::fetchInstr;
            end
            state[quarkPkg::waitAluOrMemBit]: begin
               if (!aluBusy && !memRsp.rbusy && !memRsp.wbusy) begin
                  state <= quarkPkg::fetchInstr;
               end
            end
            default: state <= quarkPkg::waitAluOrMem;
         endcase
      end
   end

   // Read strobe on fetch and on a load's execute
   assign rstrb = state[quarkPkg::fetchInstrBit] |
                  (state[quarkPkg::executeBit] & dec.opClass.load);

   // Word stores only
   assign wmask = {4{state[quarkPkg::executeBit] & dec.opClass.store}};
   assign wdata = rs2;

   // Shift loads the ALU shifter
   assign aluStart = state[quarkPkg::executeBit] & isAlu;

   // Rewritten each wait cycle, last one wins
   assign writeBack = !(dec.opClass.branch | dec.opClass.store) &
                      (state[quarkPkg::executeBit] | state[quarkPkg::waitAluOrMemBit]);

   // Unknown opcodes select nothing and write zero
   assign writeBackData =
      (dec.opClass.lui                    ? dec.uImm     : 32'd0) |
      (isAlu                              ? aluOut       : 32'd0) |
      (dec.opClass.auipc                  ? pcPlusImm    : 32'd0) |
      ((dec.opClass.jal | dec.opClass.jalr) ? pcPlus4    : 32'd0) |
      (dec.opClass.load                   ? memRsp.rdata : 32'd0);

endmodule

/* hw/quarkCore.sv */
`timescale 1ns/100ps

module quarkCore #(
   parameter logic [31:0] resetAddr = 32'h0000_0000,
   parameter int          addrWidth = 24
) (
   input  logic              clk,
   input  logic              reset,
   output quarkPkg::memReq_t memReq,
   input  quarkPkg::memRsp_t memRsp
);

   quarkPkg::instrWord_u instr;
   quarkPkg::decoded_t   dec;
   quarkPkg::fsmState_t  state;
   quarkPkg::xlen_t      rs1;
   quarkPkg::xlen_t      rs2;
   quarkPkg::xlen_t      aluOut;
   quarkPkg::xlen_t      aluPlus;
   quarkPkg::xlen_t      pcPlus4;
   quarkPkg::xlen_t      pcPlusImm;
   quarkPkg::xlen_t      memAddr;
   quarkPkg::xlen_t      writeBackData;
   quarkPkg::xlen_t      wdata;
   logic [3:0]           wmask;
   logic                 rstrb;
   logic                 predicate;
   logic                 aluBusy;
   logic                 aluStart;
   logic                 latch;
   logic                 writeBack;

   // Decode of the latched instruction
   instrDecoder u_instrDecoder (
      .instr (instr),
      .dec   (dec)
   );

   // Source indices come from the word on the bus, not the latched one
   regFile u_regFile (
      .clk           (clk),
      .srcWord       (memRsp.rdata),
      .latch         (latch),
      .writeBack     (writeBack),
      .rd            (dec.rd),
      .writeBackData (writeBackData),
      .rs1           (rs1),
      .rs2           (rs2)
   );

   execUnit u_execUnit (
      .clk       (clk),
      .reset     (reset),
      .dec       (dec),
      .rs1       (rs1),
      .rs2       (rs2),
      .start     (aluStart),
      .aluOut    (aluOut),
      .aluPlus   (aluPlus),
      .predicate (predicate),
      .aluBusy   (aluBusy)
   );

   // pc output left open, memAddr already carries it during fetch
   pcUnit #(
      .resetAddr (resetAddr),
      .addrWidth (addrWidth)
   ) u_pcUnit (
      .clk       (clk),
      .reset     (reset),
      .state     (state),
      .dec       (dec),
      .rs1       (rs1),
      .aluPlus   (aluPlus),
      .predicate (predicate),
      .pc        (),
      .pcPlus4   (pcPlus4),
      .pcPlusImm (pcPlusImm),
      .memAddr   (memAddr)
   );

   controlFsm u_controlFsm (
      .clk           (clk),
      .reset         (reset),
      .dec           (dec),
      .memRsp        (memRsp),
      .aluBusy       (aluBusy),
      .aluOut        (aluOut),
      .pcPlus4       (pcPlus4),
      .pcPlusImm     (pcPlusImm),
      .rs2           (rs2),
      .state         (state),
      .instr         (instr),
      .latch         (latch),
      .aluStart      (aluStart),
      .writeBack     (writeBack),
      .writeBackData (writeBackData),
      .wdata         (wdata),
      .wmask         (wmask),
      .rstrb         (rstrb)
   );

   // Memory bus outputs
   assign memReq = '{addr: memAddr, wdata: wdata, wmask: wmask, rstrb: rstrb};

endmodule

/* dv/quarkMemModel.sv */
`timescale 1ns/100ps

module quarkMemModel #(
   parameter int          words = 256,
   parameter logic [31:0] seed  = 32'hbcf8
) (
   input  logic              clk,
   input  logic              reset,
   input  int                maxBusy,
   input  quarkPkg::memReq_t memReq,
   output quarkPkg::memRsp_t memRsp
);

   localparam int idxBits = $clog2(words);

   // Word storage, preloaded by the testbench through hierarchy
   logic [31:0] mem [words];

   logic [31:0] readData;
   int          readWait;
   int          writeWait;
   integer      seedVar = seed;

   // Random stretch of 0 to maxBusy cycles, none when maxBusy is 0
   function automatic int busyCycles();
      int draw;
      if (maxBusy <= 0) begin
         return 0;
      end
      draw = $random(seedVar);
      return (draw & 32'h7FFF_FFFF) % (maxBusy + 1);
   endfunction

   always @(posedge clk) begin
      if (!reset) begin
         readData  <= 32'd0;
         readWait  <= 0;
         writeWait <= 0;
      end else begin
         // Read data registered on the strobe, held until the next strobe
         if (memReq.rstrb) begin
            readData <= mem[memReq.addr[idxBits+1:2]];
            readWait <= busyCycles();
         end else if (readWait > 0) begin
            readWait <= readWait - 1;
         end
         // Whole word captured in the store's execute cycle
         if (memReq.wmask != 4'd0) begin
            mem[memReq.addr[idxBits+1:2]] <= memReq.wdata;
            writeWait <= busyCycles();
         end else if (writeWait > 0) begin
            writeWait <= writeWait - 1;
         end
      end
   end

   assign memRsp = '{rdata: readData, rbusy: (readWait != 0), wbusy: (writeWait != 0)};

endmodule

/* dv/quarkCoreTb.sv */
`timescale 1ns/100ps

module quarkCoreTb;

   localparam logic [31:0] resetAddr     = 32'h0000_0080;
   localparam logic [31:0] dataAddr      = 32'h0000_0300;
   localparam logic [31:0] loadData      = 32'h5A5A_C3C3;
   localparam int          timeoutCycles = 200;
   localparam int          quietCycles   = 60;

   // RV32I major opcodes used by the assembler functions
   localparam logic [6:0] opLoad  = 7'b0000011;
   localparam logic [6:0] opImm   = 7'b0010011;
   localparam logic [6:0] opAuipc = 7'b0010111;
   localparam logic [6:0] opLui   = 7'b0110111;
   localparam logic [6:0] opJalr  = 7'b1100111;

   // One expected bus store
   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] data;
   } storeRec_t;

   logic              clk;
   logic              reset;
   int                maxBusy;
   quarkPkg::memReq_t memReq;
   quarkPkg::memRsp_t memRsp;
   logic [31:0]       progTable [$];
   storeRec_t         expTable [$];
   int                errors;
   int                checks;
   bit                stalled;

   quarkCore #(
      .resetAddr (resetAddr),
      .addrWidth (24)
   ) u_quarkCore (
      .clk    (clk),
      .reset  (reset),
      .memReq (memReq),
      .memRsp (memRsp)
   );

   quarkMemModel #(
      .words (256),
      .seed  (32'hbcf8)
   ) u_mem (
      .clk     (clk),
      .reset   (reset),
      .maxBusy (maxBusy),
      .memReq  (memReq),
      .memRsp  (memRsp)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // One instruction encoder per RV32I format
   function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] iType(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
      return {imm, rs1, f3, rd, op};
   endfunction

   // Word store only
   function automatic logic [31:0] sType(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [11:0] imm);
      return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] bType(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] imm);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic logic [31:0] uType(input logic [6:0] op, input logic [4:0] rd,
                                         input logic [19:0] imm);
      return {imm, rd, op};
   endfunction

   function automatic logic [31:0] jType(input logic [4:0] rd, input logic [20:0] imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   task automatic buildTables();
      // x31 = store base 0x380, x1 = 0x123, x2 = -5
      progTable.push_back(iType(opImm, 3'd0, 5'd31, 5'd0, 12'h380));
      progTable.push_back(iType(opImm, 3'd0, 5'd1, 5'd0, 12'h123));
      progTable.push_back(iType(opImm, 3'd0, 5'd2, 5'd0, 12'hFFB));
      // add, sub, xor, or, and, slt x2<x1, sltu x2<x1
      progTable.push_back(rType(7'h00, 3'd0, 5'd3, 5'd1, 5'd2));
      progTable.push_back(sType(5'd3, 5'd31, 12'd0));
      progTable.push_back(rType(7'h20, 3'd0, 5'd4, 5'd1, 5'd2));
      progTable.push_back(sType(5'd4, 5'd31, 12'd4));
      progTable.push_back(rType(7'h00, 3'd4, 5'd5, 5'd1, 5'd2));
      progTable.push_back(sType(5'd5, 5'd31, 12'd8));
      progTable.push_back(rType(7'h00, 3'd6, 5'd6, 5'd1, 5'd2));
      progTable.push_back(sType(5'd6, 5'd31, 12'd12));
      progTable.push_back(rType(7'h00, 3'd7, 5'd7, 5'd1, 5'd2));
      progTable.push_back(sType(5'd7, 5'd31, 12'd16));
      progTable.push_back(rType(7'h00, 3'd2, 5'd8, 5'd2, 5'd1));
      progTable.push_back(sType(5'd8, 5'd31, 12'd20));
      progTable.push_back(rType(7'h00, 3'd3, 5'd9, 5'd2, 5'd1));
      progTable.push_back(sType(5'd9, 5'd31, 12'd24));
      // xori, sltiu -1, andi, then slti -4 merged with ori 0x640
      progTable.push_back(iType(opImm, 3'd4, 5'd10, 5'd1, 12'h0F0));
      progTable.push_back(sType(5'd10, 5'd31, 12'd28));
      progTable.push_back(iType(opImm, 3'd3, 5'd11, 5'd1, 12'hFFF));
      progTable.push_back(sType(5'd11, 5'd31, 12'd32));
      progTable.push_back(iType(opImm, 3'd7, 5'd12, 5'd2, 12'h7F0));
      progTable.push_back(sType(5'd12, 5'd31, 12'd36));
      progTable.push_back(iType(opImm, 3'd2, 5'd13, 5'd2, 12'hFFC));
      progTable.push_back(iType(opImm, 3'd6, 5'd13, 5'd13, 12'h640));
      progTable.push_back(sType(5'd13, 5'd31, 12'd40));
      // lui, then auipc at word 28
      progTable.push_back(uType(opLui, 5'd14, 20'hABCDE));
      progTable.push_back(sType(5'd14, 5'd31, 12'd44));
      progTable.push_back(uType(opAuipc, 5'd15, 20'h00001));
      progTable.push_back(sType(5'd15, 5'd31, 12'd48));
      // Immediate shifts by 1 and 31
      progTable.push_back(iType(opImm, 3'd1, 5'd16, 5'd14, 12'h001));
      progTable.push_back(sType(5'd16, 5'd31, 12'd52));
      progTable.push_back(iType(opImm, 3'd5, 5'd17, 5'd14, 12'h001));
      progTable.push_back(sType(5'd17, 5'd31, 12'd56));
      progTable.push_back(iType(opImm, 3'd5, 5'd18, 5'd14, 12'h401));
      progTable.push_back(sType(5'd18, 5'd31, 12'd60));
      progTable.push_back(iType(opImm, 3'd1, 5'd19, 5'd1, 12'h01F));
      progTable.push_back(sType(5'd19, 5'd31, 12'd64));
      progTable.push_back(iType(opImm, 3'd5, 5'd20, 5'd14, 12'h01F));
      progTable.push_back(sType(5'd20, 5'd31, 12'd68));
      progTable.push_back(iType(opImm, 3'd5, 5'd21, 5'd14, 12'h41F));
      progTable.push_back(sType(5'd21, 5'd31, 12'd72));
      // Register shifts by x0
      progTable.push_back(rType(7'h00, 3'd1, 5'd22, 5'd14, 5'd0));
      progTable.push_back(sType(5'd22, 5'd31, 12'd76));
      progTable.push_back(rType(7'h00, 3'd5, 5'd23, 5'd14, 5'd0));
      progTable.push_back(sType(5'd23, 5'd31, 12'd80));
      progTable.push_back(rType(7'h20, 3'd5, 5'd24, 5'd14, 5'd0));
      progTable.push_back(sType(5'd24, 5'd31, 12'd84));
      // Branch pairs with the taken one first
      // A taken branch skips a store at offset 256 and up
      progTable.push_back(bType(3'd0, 5'd1, 5'd1, 13'd8));
      progTable.push_back(sType(5'd8, 5'd31, 12'd256));
      progTable.push_back(bType(3'd0, 5'd1, 5'd2, 13'd8));
      progTable.push_back(sType(5'd8, 5'd31, 12'd88));
      progTable.push_back(bType(3'd1, 5'd1, 5'd2, 13'd8));
      progTable.push_back(sType(5'd8, 5'd31, 12'd260));
      progTable.push_back(bType(3'd1, 5'd1, 5'd1, 13'd8));
      progTable.push_back(sType(5'd8, 5'd31, 12'd92));
      progTable.push_back(bType(3'd4, 5'd2, 5'd1, 13'd8));
      progTable.push_back(sType(5'd8, 5'd31, 12'd264));
      progTable.push_back(bType(3'd4, 5'd1, 5'd2, 13'd8));
      progTable.push_back(sType(5'd8, 5'd31, 12'd96));
      progTable.push_back(bType(3'd5, 5'd1, 5'd2, 13'd8));
      progTable.push_back(sType(5'd8, 5'd31, 12'd268));
      progTable.push_back(bType(3'd5, 5'd2, 5'd1, 13'd8));
      progTable.push_back(sType(5'd8, 5'd31, 12'd100));
      progTable.push_back(bType(3'd6, 5'd1, 5'd2, 13'd8));
      progTable.push_back(sType(5'd8, 5'd31, 12'd272));
      progTable.push_back(bType(3'd6, 5'd2, 5'd1, 13'd8));
      progTable.push_back(sType(5'd8, 5'd31, 12'd104));
      progTable.push_back(bType(3'd7, 5'd2, 5'd1, 13'd8));
      progTable.push_back(sType(5'd8, 5'd31, 12'd276));
      progTable.push_back(bType(3'd7, 5'd1, 5'd2, 13'd8));
      progTable.push_back(sType(5'd8, 5'd31, 12'd108));
      // jal over one store at word 72
      progTable.push_back(jType(5'd27, 21'd8));
      progTable.push_back(sType(5'd8, 5'd31, 12'd280));
      progTable.push_back(sType(5'd27, 5'd31, 12'd112));
      // jalr with an odd offset from auipc at word 75 lands on word 78
      progTable.push_back(uType(opAuipc, 5'd29, 20'h00000));
      progTable.push_back(iType(opJalr, 3'd0, 5'd28, 5'd29, 12'd13));
      progTable.push_back(sType(5'd8, 5'd31, 12'd284));
      progTable.push_back(sType(5'd28, 5'd31, 12'd116));
      // lw from dataAddr, write to x0, then spin
      progTable.push_back(iType(opLoad, 3'd2, 5'd30, 5'd31, 12'hF80));
      progTable.push_back(sType(5'd30, 5'd31, 12'd120));
      progTable.push_back(iType(opImm, 3'd0, 5'd0, 5'd0, 12'd5));
      progTable.push_back(sType(5'd0, 5'd31, 12'd124));
      progTable.push_back(jType(5'd0, 21'd0));

      // Expected stores in program order
      expTable.push_back({32'h380, 32'h0000_011E});
      expTable.push_back({32'h384, 32'h0000_0128});
      expTable.push_back({32'h388, 32'hFFFF_FED8});
      expTable.push_back({32'h38C, 32'hFFFF_FFFB});
      expTable.push_back({32'h390, 32'h0000_0123});
      expTable.push_back({32'h394, 32'h0000_0001});
      expTable.push_back({32'h398, 32'h0000_0000});
      expTable.push_back({32'h39C, 32'h0000_01D3});
      expTable.push_back({32'h3A0, 32'h0000_0001});
      expTable.push_back({32'h3A4, 32'h0000_07F0});
      expTable.push_back({32'h3A8, 32'h0000_0641});
      expTable.push_back({32'h3AC, 32'hABCD_E000});
      expTable.push_back({32'h3B0, resetAddr + 32'd112 + 32'h1000});
      expTable.push_back({32'h3B4, 32'h579B_C000});
      expTable.push_back({32'h3B8, 32'h55E6_F000});
      expTable.push_back({32'h3BC, 32'hD5E6_F000});
      expTable.push_back({32'h3C0, 32'h8000_0000});
      expTable.push_back({32'h3C4, 32'h0000_0001});
      expTable.push_back({32'h3C8, 32'hFFFF_FFFF});
      expTable.push_back({32'h3CC, 32'hABCD_E000});
      expTable.push_back({32'h3D0, 32'hABCD_E000});
      expTable.push_back({32'h3D4, 32'hABCD_E000});
      // Only the not-taken branches store
      expTable.push_back({32'h3D8, 32'h0000_0001});
      expTable.push_back({32'h3DC, 32'h0000_0001});
      expTable.push_back({32'h3E0, 32'h0000_0001});
      expTable.push_back({32'h3E4, 32'h0000_0001});
      expTable.push_back({32'h3E8, 32'h0000_0001});
      expTable.push_back({32'h3EC, 32'h0000_0001});
      // Link values are the jump address plus 4
      expTable.push_back({32'h3F0, resetAddr + 32'd288 + 32'd4});
      expTable.push_back({32'h3F4, resetAddr + 32'd304 + 32'd4});
      expTable.push_back({32'h3F8, loadData});
      expTable.push_back({32'h3FC, 32'h0000_0000});
   endtask

   // Fill holds the word index so stray fetches stand out
   task automatic loadMemory();
      for (int i = 0; i < 256; i++) begin
         u_mem.mem[i] = 32'h0BAD_0000 | i;
      end
      foreach (progTable[i]) begin
         u_mem.mem[resetAddr[9:2] + i] = progTable[i];
      end
      u_mem.mem[dataAddr[9:2]] = loadData;
   endtask

   // Reset, reload and run the program once at the given busy stretch
   task automatic runPass(input int busy);
      int cycles;
      @(posedge clk);
      reset   <= 1'b0;
      maxBusy <= busy;
      loadMemory();
      repeat (16) @(posedge clk);
      reset <= 1'b1;

      // First fetch comes from resetAddr with no write before it
      cycles = 0;
      @(negedge clk);
      while (!memReq.rstrb && cycles < timeoutCycles) begin
         checks++;
         assert (memReq.wmask == 4'd0) else begin
            $display("** Error at %0t: wmask %h before the first fetch", $time, memReq.wmask);
            errors++;
         end
         @(negedge clk);
         cycles++;
      end
      if (cycles >= timeoutCycles) begin
         $display("No read strobe after reset within %0d cycles (busy %0d)", cycles, busy);
         errors++;
         stalled = 1'b1;
         return;
      end
      checks++;
      assert (memReq.addr == resetAddr) else begin
         $display("** Error at %0t: first fetch expected %h, got %h", $time, resetAddr,
                  memReq.addr);
         errors++;
      end

      // Every store writes all four bytes
      foreach (expTable[idx]) begin
         cycles = 0;
         @(negedge clk);
         while (memReq.wmask == 4'd0 && cycles < timeoutCycles) begin
            @(negedge clk);
            cycles++;
         end
         if (cycles >= timeoutCycles) begin
            $display("Program stalled: store %0d never appeared (busy %0d)", idx, busy);
            errors++;
            stalled = 1'b1;
            return;
         end
         checks++;
         assert (memReq.addr == expTable[idx].addr && memReq.wdata == expTable[idx].data &&
                 memReq.wmask == 4'hF)
         else begin
            $display("** Error at %0t: store %0d expected %h = %h mask f, got %h = %h mask %h",
                     $time, idx, expTable[idx].addr, expTable[idx].data, memReq.addr,
                     memReq.wdata, memReq.wmask);
            errors++;
         end
      end

      // Program now spins on itself and stores nothing more
      for (int i = 0; i < quietCycles; i++) begin
         @(negedge clk);
         checks++;
         assert (memReq.wmask == 4'd0) else begin
            $display("** Error at %0t: extra store [%h] = %h", $time, memReq.addr,
                     memReq.wdata);
            errors++;
         end
      end
   endtask

   initial begin
      reset   = 1'b0;
      maxBusy = 0;
      errors  = 0;
      checks  = 0;
      stalled = 1'b0;
      buildTables();
      // Idle bus first and then random rbusy/wbusy stretching
      runPass(0);
      if (!stalled) begin
         runPass(3);
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* quarkCore.f */
hw/quarkPkg.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/execUnit.sv
hw/pcUnit.sv
hw/controlFsm.sv
hw/quarkCore.sv
dv/quarkMemModel.sv
dv/quarkCoreTb.sv
